// ==== compile.f ====
src/apb_pkg.sv
src/xbar_pkg.sv
src/apb_addr_decoder.sv
src/apb_wrr_arbiter.sv
src/apb_slave_port.sv
src/apb_xbar.sv
src/apb_mem_slave.sv
src/apb_xbar_subsys.sv
verif/apb_xbar_tb.sv

// ==== src/apb_addr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_addr_decoder
    import apb_pkg::*;
    import xbar_pkg::*;
(
    input  apb_req_t [XBAR_M-1:0]              m_req,
    input  region_t  [XBAR_S-1:0]              region,
    output logic     [XBAR_M-1:0][XBAR_S-1:0]  sel,
    output logic     [XBAR_M-1:0]              miss
);

    logic [XBAR_M-1:0][XBAR_S-1:0] hit;

    // Raw window compare for every master against every region
    always_comb begin
        for (int i = 0; i < XBAR_M; i++) begin
            for (int j = 0; j < XBAR_S; j++) begin
                hit[i][j] = m_req[i].psel && region[j].enable &&
                            (m_req[i].paddr >= region[j].base) &&
                            (m_req[i].paddr <= region[j].limit);
            end
        end
    end

    // Priority pick
    // Walk from the top so the lowest matching slave is written last
    always_comb begin
        sel  = '0;
        miss = '0;
        for (int i = 0; i < XBAR_M; i++) begin
            for (int j = XBAR_S - 1; j >= 0; j--) begin
                if (hit[i][j]) begin
                    sel[i] = XBAR_S'(1) << j;
                end
            end
            // Selected but nowhere to go
            miss[i] = m_req[i].psel && (hit[i] == '0);
        end
    end

endmodule

`default_nettype wire

// ==== src/apb_mem_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_mem_slave
    import apb_pkg::*;
    import xbar_pkg::*;
#(
    parameter int WAIT_STATES = 0
) (
    input  logic              aclk,
    input  logic              rst_n,
    input  logic [APB_AW-1:0] base,
    input  apb_req_t          s_req,
    output apb_rsp_t          s_rsp
);

    logic [APB_DW-1:0] mem [MEM_WORDS];

    logic [APB_AW-1:0] offset;
    logic [MEM_AW-1:0] word_idx;
    logic              out_of_range;
    logic [WAIT_W-1:0] wait_cnt;
    logic              access;
    logic              ack;

    // Byte offset inside the window
    // Addresses below base wrap to a large offset and fail
    assign offset       = s_req.paddr - base;
    assign word_idx     = offset[APB_BW +: MEM_AW];
    assign out_of_range = |offset[APB_AW-1:APB_BW+MEM_AW];

    assign access = s_req.psel && s_req.penable;
    assign ack    = access && (wait_cnt == WAIT_W'(WAIT_STATES));

    // Access cycles seen so far
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (ack) begin
            wait_cnt <= '0;
        end else if (access) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // Strobed write on completion
    always_ff @(posedge aclk) begin
        if (ack && s_req.pwrite && !out_of_range) begin
            for (int b = 0; b < APB_SW; b++) begin
                if (s_req.pstrb[b]) begin
                    mem[word_idx][8*b +: 8] <= s_req.pwdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        s_rsp.pready  = ack;
        s_rsp.pslverr = ack && out_of_range;
        s_rsp.prdata  = (ack && !s_req.pwrite && !out_of_range) ? mem[word_idx] : '0;
    end

    // Wait count rests outside an access so the next ready cannot come early
    a_ready_in_access: assert property (@(posedge aclk) disable iff (!rst_n)
        !access |-> (wait_cnt == '0));

endmodule

`default_nettype wire

// ==== src/apb_pkg.sv ====
`default_nettype none

package apb_pkg;

    // Bus widths
    localparam int APB_AW = 32;
    localparam int APB_DW = 32;
    localparam int APB_SW = 4;

    // Byte offset bits inside one data word
    localparam int APB_BW = $clog2(APB_SW);

    // One master-side or slave-side request bundle
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [APB_DW-1:0] pwdata;
        logic [APB_SW-1:0] pstrb;
    } apb_req_t;

    // Matching response bundle
    typedef struct packed {
        logic              pready;
        logic [APB_DW-1:0] prdata;
        logic              pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// ==== src/apb_slave_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_slave_port
    import apb_pkg::*;
    import xbar_pkg::*;
(
    input  logic                      aclk,
    input  logic                      rst_n,
    input  logic     [XBAR_M-1:0]     req_bits,
    input  apb_req_t [XBAR_M-1:0]     m_req,
    input  thresh_t  [XBAR_M-1:0]     thresholds,
    output apb_req_t                  s_req,
    input  apb_rsp_t                  s_rsp,
    output logic     [XBAR_M-1:0]     gnt,
    output logic                      gnt_valid
);

    port_state_e state;
    apb_req_t    gnt_req;
    logic        arb_idle;
    logic        arb_done;

    // Arbiter may only pick while no transfer runs here
    assign arb_idle = (state == PORT_IDLE);
    // Transfer ends on the slave's ready in access
    assign arb_done = (state == PORT_ACCESS) && s_rsp.pready;

    apb_wrr_arbiter arb0 (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .req        (req_bits),
        .thresholds (thresholds),
        .idle       (arb_idle),
        .done       (arb_done),
        .gnt        (gnt),
        .gnt_valid  (gnt_valid)
    );

    // Phase sequencer
    // Grant lands together with the move to setup
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= PORT_IDLE;
        end else begin
            case (state)
                PORT_IDLE:   if (|req_bits) state <= PORT_SETUP;
                PORT_SETUP:  state <= PORT_ACCESS;
                PORT_ACCESS: if (s_rsp.pready) state <= PORT_IDLE;
                default:     state <= PORT_IDLE;
            endcase
        end
    end

    // AND-OR select of the granted master
    always_comb begin
        gnt_req = '0;
        for (int i = 0; i < XBAR_M; i++) begin
            if (gnt[i]) begin
                gnt_req = m_req[i];
            end
        end
    end

    // Own psel and penable
    // The master's phase bits are not forwarded
    always_comb begin
        s_req = '0;
        if (state != PORT_IDLE) begin
            s_req         = gnt_req;
            s_req.psel    = 1'b1;
            s_req.penable = (state == PORT_ACCESS);
        end
    end

    // Access follows one setup cycle of a master that still selects this slave
    a_setup_first: assert property (@(posedge aclk) disable iff (!rst_n)
        $rose(s_req.penable) |-> $past(s_req.psel && !s_req.penable && |(gnt & req_bits)));

    // Granted master holds its fields through access
    a_stable_access: assert property (@(posedge aclk) disable iff (!rst_n)
        s_req.penable |-> $stable({s_req.pwrite, s_req.paddr, s_req.pwdata, s_req.pstrb}));

endmodule

`default_nettype wire

// ==== src/apb_wrr_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_wrr_arbiter
    import xbar_pkg::*;
(
    input  logic                     aclk,
    input  logic                     rst_n,
    input  logic    [XBAR_M-1:0]     req,
    input  thresh_t [XBAR_M-1:0]     thresholds,
    input  logic                     idle,
    input  logic                     done,
    output logic    [XBAR_M-1:0]     gnt,
    output logic                     gnt_valid
);

    // Round-robin start point and last winner
    logic [M_IDX_W-1:0] ptr;
    logic [M_IDX_W-1:0] holder;
    // Consecutive grants per master
    logic [XBAR_M-1:0][CNT_W-1:0] run_cnt;

    logic [CNT_W-1:0]   holder_lim;
    logic               keep;
    logic [M_IDX_W-1:0] rr_idx;
    logic               rr_found;

    // Threshold of 0 behaves as 1
    always_comb begin
        holder_lim = (thresholds[holder] == '0) ? CNT_W'(1) : CNT_W'(thresholds[holder]);
        keep = req[holder] && (run_cnt[holder] != '0) && (run_cnt[holder] < holder_lim);
    end

    // First requester at or after ptr
    // Descending offsets so the nearest one is written last
    always_comb begin
        rr_idx   = ptr;
        rr_found = 1'b0;
        for (int k = XBAR_M - 1; k >= 0; k--) begin
            if (req[(int'(ptr) + k) % XBAR_M]) begin
                rr_idx   = M_IDX_W'((int'(ptr) + k) % XBAR_M);
                rr_found = 1'b1;
            end
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            ptr       <= '0;
            holder    <= '0;
            gnt       <= '0;
            gnt_valid <= 1'b0;
            run_cnt   <= '0;
        end else if (idle && rr_found) begin
            gnt_valid <= 1'b1;
            if (keep) begin
                // Holder stays and extends its run
                // Keep already caps the run below the threshold
                gnt <= XBAR_M'(1) << holder;
                run_cnt[holder] <= run_cnt[holder] + 1'b1;
            end else begin
                gnt    <= XBAR_M'(1) << rr_idx;
                holder <= rr_idx;
                ptr    <= (rr_idx == M_IDX_W'(XBAR_M - 1)) ? '0 : rr_idx + 1'b1;
                // New run starts at one and every other count clears
                for (int i = 0; i < XBAR_M; i++) begin
                    run_cnt[i] <= (i == int'(rr_idx)) ? CNT_W'(1) : '0;
                end
            end
        end else if (done) begin
            gnt_valid <= 1'b0;
            gnt       <= '0;
        end
    end

    // A new grant names exactly one master and that master was asking
    a_gnt_onehot: assert property (@(posedge aclk) disable iff (!rst_n)
        $rose(gnt_valid) |-> $onehot(gnt) && |(gnt & $past(req)));

endmodule

`default_nettype wire

// ==== src/apb_xbar.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_xbar
    import apb_pkg::*;
    import xbar_pkg::*;
(
    input  logic                      aclk,
    input  logic                      rst_n,
    input  region_t  [XBAR_S-1:0]     region,
    input  thresh_t  [XBAR_M-1:0]     thresholds,
    input  apb_req_t [XBAR_M-1:0]     m_req,
    output apb_rsp_t [XBAR_M-1:0]     m_rsp,
    output apb_req_t [XBAR_S-1:0]     s_req,
    input  apb_rsp_t [XBAR_S-1:0]     s_rsp
);

    logic [XBAR_M-1:0][XBAR_S-1:0] dec_sel;
    logic [XBAR_M-1:0]             dec_miss;
    // Per slave view of the decode
    logic [XBAR_S-1:0][XBAR_M-1:0] port_req;
    logic [XBAR_S-1:0][XBAR_M-1:0] port_gnt;
    logic [XBAR_S-1:0]             port_gnt_valid;
    // owner[i][j] means port j is serving master i
    logic [XBAR_M-1:0][XBAR_S-1:0] owner;
    err_state_e [XBAR_M-1:0]       err_state;

    apb_addr_decoder dec0 (
        .m_req  (m_req),
        .region (region),
        .sel    (dec_sel),
        .miss   (dec_miss)
    );

    always_comb begin
        for (int i = 0; i < XBAR_M; i++) begin
            for (int j = 0; j < XBAR_S; j++) begin
                port_req[j][i] = dec_sel[i][j];
                owner[i][j]    = port_gnt_valid[j] && port_gnt[j][i];
            end
        end
    end

    for (genvar j = 0; j < XBAR_S; j++) begin : g_port
        apb_slave_port port0 (
            .aclk       (aclk),
            .rst_n      (rst_n),
            .req_bits   (port_req[j]),
            .m_req      (m_req),
            .thresholds (thresholds),
            .s_req      (s_req[j]),
            .s_rsp      (s_rsp[j]),
            .gnt        (port_gnt[j]),
            .gnt_valid  (port_gnt_valid[j])
        );
    end

    // Decode error responder
    // Only a setup cycle that misses starts one
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < XBAR_M; i++) begin
                err_state[i] <= ERR_IDLE;
            end
        end else begin
            for (int i = 0; i < XBAR_M; i++) begin
                case (err_state[i])
                    ERR_IDLE: begin
                        if (dec_miss[i] && !m_req[i].penable) begin
                            err_state[i] <= ERR_RESP;
                        end
                    end
                    default: err_state[i] <= ERR_IDLE;
                endcase
            end
        end
    end

    // Return path
    always_comb begin
        for (int i = 0; i < XBAR_M; i++) begin
            m_rsp[i] = '0;
            if (err_state[i] == ERR_RESP) begin
                m_rsp[i].pready  = 1'b1;
                m_rsp[i].pslverr = 1'b1;
            end
            for (int j = 0; j < XBAR_S; j++) begin
                if (owner[i][j]) begin
                    // Ready only counts in the slave's access phase
                    m_rsp[i].pready  = s_rsp[j].pready && s_req[j].penable;
                    m_rsp[i].prdata  = s_rsp[j].prdata;
                    m_rsp[i].pslverr = s_rsp[j].pslverr;
                end
            end
        end
    end

    for (genvar i = 0; i < XBAR_M; i++) begin : g_chk
        a_single_owner: assert property (@(posedge aclk) disable iff (!rst_n)
            $onehot0(owner[i]));
    end

endmodule

`default_nettype wire

// ==== src/apb_xbar_subsys.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_xbar_subsys
    import apb_pkg::*;
    import xbar_pkg::*;
(
    input  logic                      aclk,
    input  logic                      rst_n,
    input  region_t  [XBAR_S-1:0]     region,
    input  thresh_t  [XBAR_M-1:0]     thresholds,
    input  apb_req_t [XBAR_M-1:0]     m_req,
    output apb_rsp_t [XBAR_M-1:0]     m_rsp
);

    apb_req_t [XBAR_S-1:0] s_req;
    apb_rsp_t [XBAR_S-1:0] s_rsp;

    apb_xbar xbar0 (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .region     (region),
        .thresholds (thresholds),
        .m_req      (m_req),
        .m_rsp      (m_rsp),
        .s_req      (s_req),
        .s_rsp      (s_rsp)
    );

    // Slave j runs with j wait states at the base of region j
    for (genvar j = 0; j < XBAR_S; j++) begin : g_mem
        apb_mem_slave #(
            .WAIT_STATES (j)
        ) mem0 (
            .aclk  (aclk),
            .rst_n (rst_n),
            .base  (region[j].base),
            .s_req (s_req[j]),
            .s_rsp (s_rsp[j])
        );
    end

endmodule

`default_nettype wire

// ==== src/xbar_pkg.sv ====
`default_nettype none

package xbar_pkg;

    // Crossbar size
    localparam int XBAR_M  = 2;
    localparam int XBAR_S  = 4;
    localparam int M_IDX_W = $clog2(XBAR_M);

    // Arbiter run lengths
    localparam int MAX_THRESH = 16;
    localparam int THRESH_W   = 4;
    localparam int CNT_W      = $clog2(MAX_THRESH + 1);

    typedef logic [THRESH_W-1:0] thresh_t;

    // One slave's address window, limit is inclusive
    typedef struct packed {
        logic                       enable;
        logic [apb_pkg::APB_AW-1:0] base;
        logic [apb_pkg::APB_AW-1:0] limit;
    } region_t;

    // Memory slave geometry
    localparam int MEM_WORDS = 64;
    localparam int MEM_AW    = $clog2(MEM_WORDS);
    localparam int WAIT_W    = 8;

    typedef enum logic [1:0] {PORT_IDLE, PORT_SETUP, PORT_ACCESS} port_state_e;
    typedef enum logic {ERR_IDLE, ERR_RESP} err_state_e;

endpackage

`default_nettype wire

// ==== verif/apb_xbar_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_xbar_tb
    import apb_pkg::*;
    import xbar_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int RST_CYC    = 5;
    // Transfer counts per test, the watchdog budget follows from them
    localparam int N_WRR    = 14;
    localparam int N_FILL   = 32;
    localparam int N_RAND   = 12;
    localparam int N_READ   = 32;
    localparam int N_LAT    = 8;
    localparam int N_PAR    = 8;
    localparam int N_DEC    = 6;
    localparam int N_OFF    = 8;
    localparam int N_XFERS  = N_WRR + N_FILL + 2 * N_RAND + N_READ + N_LAT + N_PAR + N_DEC + N_OFF;
    localparam int WDOG_CYC = N_XFERS * 40 + RST_CYC;
    // Byte span that one memory slave answers
    localparam logic [APB_AW-1:0] MEM_BYTES = APB_AW'(MEM_WORDS * APB_SW);

    logic                  aclk;
    logic                  rst_n;
    region_t  [XBAR_S-1:0] region;
    thresh_t  [XBAR_M-1:0] thresholds;
    apb_req_t [XBAR_M-1:0] m_req;
    apb_rsp_t [XBAR_M-1:0] m_rsp;

    // Mirror of all four memories
    logic [APB_DW-1:0] ref_mem [XBAR_S][MEM_WORDS];
    // Expected response of each master's open transfer
    logic [APB_DW-1:0] exp_rdata [XBAR_M];
    logic              exp_err   [XBAR_M];
    int                exp_lat   [XBAR_M];
    logic              data_chk  [XBAR_M];
    logic              lat_chk   [XBAR_M];
    // Cycles since each master's setup cycle
    int                lat_cnt   [XBAR_M];
    logic [XBAR_M-1:0] fin;
    int                done_order [$];
    string             test_name;

    apb_xbar_subsys dut0 (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .region     (region),
        .thresholds (thresholds),
        .m_req      (m_req),
        .m_rsp      (m_rsp)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "Run stopped at the first failing check");
    endtask

    // Region j sits at (j+1) * 64 KiB with a 4 KiB window
    function automatic region_t default_region(input int j);
        return '{enable: 1'b1, base: APB_AW'(j + 1) << 16,
                 limit: (APB_AW'(j + 1) << 16) + 32'h0000_0FFF};
    endfunction

    function automatic logic [APB_AW-1:0] word_addr(input int s, input int w);
        return region[s].base + APB_AW'(w * APB_SW);
    endfunction

    // First enabled window that holds the address, or -1
    function automatic int expected_slave(input logic [APB_AW-1:0] addr);
        for (int j = 0; j < XBAR_S; j++) begin
            if (region[j].enable && addr >= region[j].base && addr <= region[j].limit) begin
                return j;
            end
        end
        return -1;
    endfunction

    // One master's full APB transfer, driven on falling edges
    task automatic apb_xfer(input int m, input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [APB_DW-1:0] wdata, input logic [APB_SW-1:0] strb,
                            input logic chk);
        int                s;
        int                w;
        logic [APB_AW-1:0] off;
        logic              err;
        logic              rdy;
        s   = expected_slave(addr);
        off = (s < 0) ? '0 : addr - region[s].base;
        w   = int'(off / APB_SW);
        err = (s < 0) || (off >= MEM_BYTES);
        @(negedge aclk);
        m_req[m] = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr,
                     pwdata: wdata, pstrb: strb};
        exp_err[m]   = err;
        exp_lat[m]   = (s < 0) ? 1 : 2 + s;
        lat_chk[m]   = chk;
        // Slave errors leave prdata open, decode misses return zero
        data_chk[m]  = (s < 0) || (!wr && !err);
        exp_rdata[m] = (wr || err) ? '0 : ref_mem[s][w];
        if (wr && !err) begin
            for (int b = 0; b < APB_SW; b++) begin
                if (strb[b]) begin
                    ref_mem[s][w][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
        // Access phase until ready, sampled before driving
        do begin
            @(negedge aclk);
            rdy = m_rsp[m].pready;
            m_req[m].penable = 1'b1;
        end while (!rdy);
    endtask

    task automatic release_bus(input int m);
        @(negedge aclk);
        m_req[m] = '0;
    endtask

    // Master m owns words 4m to 4m+3 of every slave
    task automatic fill_words(input int m);
        for (int s = 0; s < XBAR_S; s++) begin
            for (int k = 0; k < 4; k++) begin
                apb_xfer(m, 1'b1, word_addr(s, 4 * m + k), $urandom, '1, 1'b0);
            end
        end
        release_bus(m);
    endtask

    task automatic rand_traffic(input int m);
        for (int k = 0; k < N_RAND; k++) begin
            apb_xfer(m, 1'b1, word_addr($urandom_range(XBAR_S - 1, 0), 4 * m + $urandom_range(3, 0)),
                     $urandom, APB_SW'($urandom), 1'b0);
        end
        for (int s = 0; s < XBAR_S; s++) begin
            for (int k = 0; k < 4; k++) begin
                apb_xfer(m, 1'b0, word_addr(s, 4 * m + k), '0, '0, 1'b0);
            end
        end
        release_bus(m);
    endtask

    // Both masters hammer slave 0, order bit k names the k-th winner
    task automatic run_wrr(input string name, input thresh_t t0, input thresh_t t1,
                           input int n0, input int n1, input logic [15:0] order);
        test_name = name;
        @(negedge aclk);
        thresholds[0] = t0;
        thresholds[1] = t1;
        done_order.delete();
        fork
            begin
                for (int k = 0; k < n0; k++) begin
                    apb_xfer(0, 1'b1, word_addr(0, k % 4), $urandom, '1, 1'b0);
                end
                release_bus(0);
            end
            begin
                for (int k = 0; k < n1; k++) begin
                    apb_xfer(1, 1'b1, word_addr(0, 4 + k % 4), $urandom, '1, 1'b0);
                end
                release_bus(1);
            end
        join
        assert (done_order.size() == n0 + n1) else begin
            $display("Error %s: completions expected %0d actual %0d",
                     test_name, n0 + n1, done_order.size());
            abort_run();
        end
        for (int k = 0; k < n0 + n1; k++) begin
            assert (done_order[k] == int'(order[k])) else begin
                $display("Error %s: completion %0d expected master %0d actual master %0d",
                         test_name, k, order[k], done_order[k]);
                abort_run();
            end
        end
    endtask

    always_comb begin
        for (int i = 0; i < XBAR_M; i++) begin
            fin[i] = m_req[i].psel && m_req[i].penable && m_rsp[i].pready;
        end
    end

    always @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < XBAR_M; i++) begin
                lat_cnt[i] <= 0;
            end
        end else begin
            for (int i = 0; i < XBAR_M; i++) begin
                if (m_req[i].psel && !m_req[i].penable) begin
                    lat_cnt[i] <= 1;
                end else if (m_req[i].psel) begin
                    lat_cnt[i] <= lat_cnt[i] + 1;
                end
            end
        end
    end

    // Completion log for the arbitration tests
    always @(posedge aclk) begin
        for (int i = 0; i < XBAR_M; i++) begin
            if (rst_n && fin[i]) begin
                done_order.push_back(i);
            end
        end
    end

    for (genvar i = 0; i < XBAR_M; i++) begin : g_chk
        a_rdata: assert property (@(posedge aclk) disable iff (!rst_n)
            fin[i] && data_chk[i] |-> m_rsp[i].prdata == exp_rdata[i])
        else begin
            $display("Error %s: master %0d prdata expected %h actual %h", test_name, i,
                     $sampled(exp_rdata[i]), $sampled(m_rsp[i].prdata));
            abort_run();
        end
        a_slverr: assert property (@(posedge aclk) disable iff (!rst_n)
            fin[i] |-> m_rsp[i].pslverr == exp_err[i])
        else begin
            $display("Error %s: master %0d pslverr expected %b actual %b", test_name, i,
                     $sampled(exp_err[i]), $sampled(m_rsp[i].pslverr));
            abort_run();
        end
        a_latency: assert property (@(posedge aclk) disable iff (!rst_n)
            fin[i] && lat_chk[i] |-> lat_cnt[i] == exp_lat[i])
        else begin
            $display("Error %s: master %0d latency expected %0d actual %0d", test_name, i,
                     $sampled(exp_lat[i]), $sampled(lat_cnt[i]));
            abort_run();
        end
    end

    initial begin
        #(WDOG_CYC * CLK_PERIOD);
        $display("Timeout: transfers still pending after %0d cycles", WDOG_CYC);
        abort_run();
    end

    initial begin
        void'($urandom(32'h9467));
        aclk       = 1'b0;
        rst_n      = 1'b0;
        m_req      = '0;
        thresholds = '0;
        for (int j = 0; j < XBAR_S; j++) begin
            region[j] = default_region(j);
        end
        repeat (RST_CYC) @(posedge aclk);
        @(negedge aclk);
        // Quiet buses while reset is held
        for (int j = 0; j < XBAR_S; j++) begin
            assert (!dut0.s_req[j].psel && !dut0.s_req[j].penable) else begin
                $display("Error reset: slave %0d psel and penable expected 00 actual %b%b",
                         j, dut0.s_req[j].psel, dut0.s_req[j].penable);
                abort_run();
            end
        end
        for (int i = 0; i < XBAR_M; i++) begin
            assert (!m_rsp[i].pready) else begin
                $display("Error reset: master %0d pready expected 0 actual 1", i);
                abort_run();
            end
        end
        rst_n = 1'b1;

        // Fresh arbiter state, so the winner order is fixed
        run_wrr("wrr_3_1", 4'd3, 4'd1, 6, 2, 16'h0088);
        run_wrr("wrr_0_0", 4'd0, 4'd0, 3, 3, 16'h002A);

        test_name = "fill";
        fork
            fill_words(0);
            fill_words(1);
        join
        test_name = "read_after_write";
        fork
            rand_traffic(0);
            rand_traffic(1);
        join

        test_name = "latency";
        for (int m = 0; m < XBAR_M; m++) begin
            for (int s = 0; s < XBAR_S; s++) begin
                apb_xfer(m, 1'b0, word_addr(s, 4 * m), '0, '0, 1'b1);
            end
            release_bus(m);
        end

        // Different slaves at once, each master keeps its own latency
        test_name = "parallel";
        for (int r = 0; r < XBAR_S; r++) begin
            fork
                begin
                    apb_xfer(0, 1'b0, word_addr(r, 0), '0, '0, 1'b1);
                    release_bus(0);
                end
                begin
                    apb_xfer(1, 1'b1, word_addr((r + 1) % XBAR_S, 4 + r), $urandom, '1, 1'b1);
                    release_bus(1);
                end
            join
        end

        test_name = "decode_miss";
        fork
            begin
                apb_xfer(0, 1'b0, 32'h0000_8000, '0, '0, 1'b1);
                release_bus(0);
            end
            begin
                apb_xfer(1, 1'b1, 32'hF000_0000, $urandom, '1, 1'b1);
                release_bus(1);
            end
        join
        test_name = "decode_disabled";
        @(negedge aclk);
        region[3].enable = 1'b0;
        for (int m = 0; m < XBAR_M; m++) begin
            apb_xfer(m, 1'b0, word_addr(3, 4 * m), '0, '0, 1'b1);
            release_bus(m);
        end
        // Region 3 laid over region 0, slave 0 must answer
        test_name = "decode_overlap";
        @(negedge aclk);
        region[3] = region[0];
        for (int m = 0; m < XBAR_M; m++) begin
            apb_xfer(m, 1'b0, word_addr(0, 4 * m), '0, '0, 1'b1);
            release_bus(m);
        end
        @(negedge aclk);
        region[3] = default_region(3);

        // Offset past the memory aliases word k, the reads show it untouched
        test_name = "offset";
        for (int k = 0; k < XBAR_S; k++) begin
            apb_xfer(0, 1'b1, region[k].base + MEM_BYTES + APB_AW'(4 * k), $urandom, '1, 1'b1);
        end
        for (int k = 0; k < XBAR_S; k++) begin
            apb_xfer(0, 1'b0, word_addr(k, k), '0, '0, 1'b1);
        end
        release_bus(0);

        repeat (2) @(negedge aclk);
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
